/* bridge_pkg.sv */
package bridge_pkg;

    // bus widths
    localparam int addr_w   = 32;
    localparam int data_w   = 32;
    localparam int strb_w   = 4;
    localparam int axi_id_w = 4;

    // read ids tell the two ports apart on the R channel
    localparam logic [axi_id_w-1:0] id_inst  = 4'd0;
    localparam logic [axi_id_w-1:0] id_data  = 4'd1;
    localparam logic [axi_id_w-1:0] id_write = 4'd1;

    // single beat, incrementing burst
    localparam logic [7:0] axi_len_single = 8'd0;
    localparam logic [1:0] axi_burst_incr = 2'b01;

    // axi size code that the sram size widens into
    typedef logic [2:0] size_t;

    // read address engine
    typedef enum logic {
        ar_idle,
        ar_wait
    } ar_state_t;

    // write engine states name the beats still owed
    typedef enum logic [1:0] {
        aw_w_idle,
        aw_w_wait_both,
        aw_w_wait_aw,
        aw_w_wait_w
    } aw_w_state_t;

endpackage

/* bridge_req_if.sv */
`timescale 1ns/1ps

interface bridge_req_if
    import bridge_pkg::*;
();

    // request side
    logic                valid;
    logic [axi_id_w-1:0] id;
    logic [addr_w-1:0]   addr;
    size_t               size;
    logic [data_w-1:0]   wdata;
    logic [strb_w-1:0]   wstrb;

    // engine still holds an earlier beat
    logic                stall;

    modport source (
        output valid, id, addr, size, wdata, wstrb,
        input  stall
    );

    modport sink (
        input  valid, id, addr, size, wdata, wstrb,
        output stall
    );

endinterface

/* sram_port_adapter.sv */
`timescale 1ns/1ps

module sram_port_adapter
    import bridge_pkg::*;
(
    // instruction port, read only
    input  logic                inst_req,
    input  logic [1:0]          inst_size,
    input  logic [addr_w-1:0]   inst_addr,
    output logic                inst_addr_ok,
    output logic                inst_data_ok,

    // data port
    input  logic                data_req,
    input  logic                data_wr,
    input  logic [1:0]          data_size,
    input  logic [strb_w-1:0]   data_wstrb,
    input  logic [addr_w-1:0]   data_addr,
    input  logic [data_w-1:0]   data_wdata,
    output logic                data_addr_ok,
    output logic                data_data_ok,

    // response side of the axi bus
    input  logic [axi_id_w-1:0] rid,
    input  logic                rvalid,
    input  logic                bvalid,

    bridge_req_if.source        rd_req,
    bridge_req_if.source        wr_req
);

    logic data_rd;
    logic data_wt;

    // split the data port by direction
    assign data_rd = data_req && !data_wr;
    assign data_wt = data_req && data_wr;

    // data read selected ahead of an instruction fetch
    assign rd_req.valid = data_rd || inst_req;
    assign rd_req.id    = data_rd ? id_data : id_inst;
    assign rd_req.addr  = data_rd ? data_addr : inst_addr;
    assign rd_req.size  = data_rd ? {1'b0, data_size} : {1'b0, inst_size};
    // reads carry no payload
    assign rd_req.wdata = '0;
    assign rd_req.wstrb = '0;

    // write request straight from the data port
    assign wr_req.valid = data_wt;
    assign wr_req.id    = id_write;
    assign wr_req.addr  = data_addr;
    assign wr_req.size  = {1'b0, data_size};
    assign wr_req.wdata = data_wdata;
    assign wr_req.wstrb = data_wstrb;

    // grants follow the stall of the serving engine
    assign inst_addr_ok = !data_rd && !rd_req.stall;
    assign data_addr_ok = (data_rd && !rd_req.stall) || (data_wt && !wr_req.stall);

    // read responses go by rid and write responses to data
    assign inst_data_ok = rvalid && (rid == id_inst);
    assign data_data_ok = (rvalid && (rid == id_data)) || bvalid;

endmodule

/* ar_channel.sv */
`timescale 1ns/1ps

module ar_channel
    import bridge_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,

    bridge_req_if.sink          req,

    input  logic                arready,
    output logic [axi_id_w-1:0] arid,
    output logic [addr_w-1:0]   araddr,
    output size_t               arsize,
    output logic                arvalid
);

    ar_state_t           state;
    ar_state_t           state_next;
    logic                stall;

    // captured copy shown while waiting
    logic [axi_id_w-1:0] id_q;
    logic [addr_w-1:0]   addr_q;
    size_t               size_q;

    // an address is out and not yet taken
    assign stall     = (state == ar_wait) && !arready;
    assign req.stall = stall;

    always_comb begin
        state_next = state;
        case (state)
            ar_idle: begin
                if (req.valid && !arready) begin
                    state_next = ar_wait;
                end
            end
            ar_wait: begin
                // a request arriving with arready is held for next cycle
                if (arready && !req.valid) begin
                    state_next = ar_idle;
                end
            end
            default: state_next = ar_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ar_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_q   <= req.id;
            addr_q <= req.addr;
            size_q <= req.size;
        end
    end

    // pass through when idle, frozen copy when waiting
    assign arvalid = (state == ar_wait) || req.valid;
    assign arid    = (state == ar_idle) ? req.id   : id_q;
    assign araddr  = (state == ar_idle) ? req.addr : addr_q;
    assign arsize  = (state == ar_idle) ? req.size : size_q;

endmodule

/* aw_w_channel.sv */
`timescale 1ns/1ps

module aw_w_channel
    import bridge_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,

    bridge_req_if.sink        req,

    input  logic              awready,
    input  logic              wready,

    output logic [addr_w-1:0] awaddr,
    output size_t             awsize,
    output logic              awvalid,

    output logic [data_w-1:0] wdata,
    output logic [strb_w-1:0] wstrb,
    output logic              wvalid
);

    aw_w_state_t       state;
    aw_w_state_t       state_next;
    logic              aw_pend;
    logic              w_pend;
    logic              stall;
    logic              aw_left;
    logic              w_left;

    // payload held for the beats still owed
    logic [addr_w-1:0] addr_q;
    size_t             size_q;
    logic [data_w-1:0] wdata_q;
    logic [strb_w-1:0] wstrb_q;

    // beats offered from the held copy
    assign aw_pend = (state == aw_w_wait_both) || (state == aw_w_wait_aw);
    assign w_pend  = (state == aw_w_wait_both) || (state == aw_w_wait_w);

    // any held beat without its ready blocks new requests
    assign stall     = (aw_pend && !awready) || (w_pend && !wready);
    assign req.stall = stall;

    // which beats are owed after this cycle
    always_comb begin
        if (stall) begin
            aw_left = aw_pend && !awready;
            w_left  = w_pend && !wready;
        end else if (state == aw_w_idle) begin
            // live request offered this cycle
            aw_left = req.valid && !awready;
            w_left  = req.valid && !wready;
        end else begin
            // new request captured and offered from next cycle
            aw_left = req.valid;
            w_left  = req.valid;
        end
    end

    always_comb begin
        case ({aw_left, w_left})
            2'b11:   state_next = aw_w_wait_both;
            2'b10:   state_next = aw_w_wait_aw;
            2'b01:   state_next = aw_w_wait_w;
            default: state_next = aw_w_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= aw_w_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            addr_q  <= req.addr;
            size_q  <= req.size;
            wdata_q <= req.wdata;
            wstrb_q <= req.wstrb;
        end
    end

    // both channels rise together with a request in idle
    assign awvalid = aw_pend || ((state == aw_w_idle) && req.valid);
    assign wvalid  = w_pend || ((state == aw_w_idle) && req.valid);

    assign awaddr = (state == aw_w_idle) ? req.addr  : addr_q;
    assign awsize = (state == aw_w_idle) ? req.size  : size_q;
    assign wdata  = (state == aw_w_idle) ? req.wdata : wdata_q;
    assign wstrb  = (state == aw_w_idle) ? req.wstrb : wstrb_q;

endmodule

/* axi_bridge_top.sv */
`timescale 1ns/1ps

module axi_bridge_top
    import bridge_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,

    // instruction port
    input  logic                inst_req,
    input  logic [1:0]          inst_size,
    input  logic [addr_w-1:0]   inst_addr,
    output logic                inst_addr_ok,
    output logic                inst_data_ok,
    output logic [data_w-1:0]   inst_rdata,

    // data port
    input  logic                data_req,
    input  logic                data_wr,
    input  logic [1:0]          data_size,
    input  logic [strb_w-1:0]   data_wstrb,
    input  logic [addr_w-1:0]   data_addr,
    input  logic [data_w-1:0]   data_wdata,
    output logic                data_addr_ok,
    output logic                data_data_ok,
    output logic [data_w-1:0]   data_rdata,

    // read address
    output logic [axi_id_w-1:0] arid,
    output logic [addr_w-1:0]   araddr,
    output logic [7:0]          arlen,
    output logic [2:0]          arsize,
    output logic [1:0]          arburst,
    output logic                arvalid,
    input  logic                arready,

    // read data
    input  logic [axi_id_w-1:0] rid,
    input  logic [data_w-1:0]   rdata,
    input  logic                rvalid,
    output logic                rready,

    // write address
    output logic [axi_id_w-1:0] awid,
    output logic [addr_w-1:0]   awaddr,
    output logic [7:0]          awlen,
    output logic [2:0]          awsize,
    output logic [1:0]          awburst,
    output logic                awvalid,
    input  logic                awready,

    // write data
    output logic [data_w-1:0]   wdata,
    output logic [strb_w-1:0]   wstrb,
    output logic                wlast,
    output logic                wvalid,
    input  logic                wready,

    // write response
    input  logic                bvalid,
    output logic                bready
);

    bridge_req_if rd_req ();
    bridge_req_if wr_req ();

    sram_port_adapter u_adapter (
        .inst_req     (inst_req),
        .inst_size    (inst_size),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_wstrb   (data_wstrb),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .rid          (rid),
        .rvalid       (rvalid),
        .bvalid       (bvalid),
        .rd_req       (rd_req.source),
        .wr_req       (wr_req.source)
    );

    ar_channel u_ar (
        .clk     (clk),
        .resetn  (resetn),
        .req     (rd_req.sink),
        .arready (arready),
        .arid    (arid),
        .araddr  (araddr),
        .arsize  (arsize),
        .arvalid (arvalid)
    );

    aw_w_channel u_aw_w (
        .clk     (clk),
        .resetn  (resetn),
        .req     (wr_req.sink),
        .awready (awready),
        .wready  (wready),
        .awaddr  (awaddr),
        .awsize  (awsize),
        .awvalid (awvalid),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid)
    );

    // single beat bursts only
    assign arlen   = axi_len_single;
    assign arburst = axi_burst_incr;
    assign awid    = id_write;
    assign awlen   = axi_len_single;
    assign awburst = axi_burst_incr;
    assign wlast   = 1'b1;

    // responses are always taken
    assign rready = 1'b1;
    assign bready = 1'b1;

    // read data shared by both ports with data_ok naming the owner
    assign inst_rdata = rdata;
    assign data_rdata = rdata;

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held low for 8 cycles and released just after an edge
    initial begin
        resetn = 1'b0;
        repeat (8) @(posedge clk);
        #1 resetn = 1'b1;
    end

endmodule

/* tb_axi_slave.sv */
`timescale 1ns/1ps

module tb_axi_slave
    import bridge_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic [axi_id_w-1:0] arid,
    input  logic [addr_w-1:0]   araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [axi_id_w-1:0] rid,
    output logic [data_w-1:0]   rdata,
    output logic                rvalid,
    input  logic [addr_w-1:0]   awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [data_w-1:0]   wdata,
    input  logic [strb_w-1:0]   wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic                bvalid
);

    logic [15:0]       lfsr;
    logic [data_w-1:0] mem [logic [29:0]];
    logic [addr_w-1:0] aw_q [$];
    logic [data_w-1:0] wd_q [$];
    logic [strb_w-1:0] ws_q [$];
    // responses in acceptance order
    logic              rsp_wr [$];
    logic [3:0]        rsp_id [$];
    logic [data_w-1:0] rsp_data [$];
    logic [31:0]       r;
    logic [31:0]       go;
    logic [data_w-1:0] word;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [data_w-1:0] fill_word(logic [addr_w-1:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h5A3C_96E1;
    endfunction

    initial begin
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        rvalid  = 1'b0;
        bvalid  = 1'b0;
        rid     = '0;
        rdata   = '0;
    end

    always @(posedge clk) begin
        if (!resetn) begin
            lfsr = 16'd47;
            aw_q.delete();
            wd_q.delete();
            ws_q.delete();
            rsp_wr.delete();
            rsp_id.delete();
            rsp_data.delete();
            #1;
            arready = 1'b0;
            awready = 1'b0;
            wready  = 1'b0;
            rvalid  = 1'b0;
            bvalid  = 1'b0;
        end else begin
            if (arvalid && arready) begin
                rsp_wr.push_back(1'b0);
                rsp_id.push_back(arid);
                rsp_data.push_back(mem.exists(araddr[31:2]) ? mem[araddr[31:2]]
                                                            : fill_word(araddr));
            end
            if (awvalid && awready) aw_q.push_back(awaddr);
            if (wvalid && wready) begin
                wd_q.push_back(wdata);
                ws_q.push_back(wstrb);
            end
            // a write completes once both of its beats are in
            if (aw_q.size() > 0 && wd_q.size() > 0) begin
                r = aw_q.pop_front();
                word = mem.exists(r[31:2]) ? mem[r[31:2]] : fill_word(r);
                for (int b = 0; b < strb_w; b++) begin
                    if (ws_q[0][b]) word[8*b +: 8] = wd_q[0][8*b +: 8];
                end
                mem[r[31:2]] = word;
                void'(wd_q.pop_front());
                void'(ws_q.pop_front());
                rsp_wr.push_back(1'b1);
                rsp_id.push_back(id_write);
                rsp_data.push_back('0);
            end
            r = take_bits(3);
            #1;
            arready = r[2];
            awready = r[1];
            wready  = r[0];
            rvalid  = 1'b0;
            bvalid  = 1'b0;
            if (rsp_wr.size() > 0) begin
                go = take_bits(1);
                if (go[0]) begin
                    rid   = rsp_id.pop_front();
                    rdata = rsp_data.pop_front();
                    if (rsp_wr.pop_front()) bvalid = 1'b1;
                    else rvalid = 1'b1;
                end
            end
        end
    end

endmodule

/* tb_axi_bridge.sv */
`timescale 1ns/1ps

module tb_axi_bridge;

    localparam int n_req = 16 + 20 + 8 + 12 + 12;

    logic clk, resetn;
    logic inst_req, inst_addr_ok, inst_data_ok;
    logic [1:0] inst_size;
    logic [31:0] inst_addr, inst_rdata;
    logic data_req, data_wr, data_addr_ok, data_data_ok;
    logic [1:0] data_size;
    logic [3:0] data_wstrb;
    logic [31:0] data_addr, data_wdata, data_rdata;
    logic [3:0] arid, rid, awid;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic [7:0] arlen, awlen;
    logic [2:0] arsize, awsize;
    logic [1:0] arburst, awburst;
    logic arvalid, arready, rvalid, rready, awvalid, awready;
    logic [3:0] wstrb;
    logic wlast, wvalid, wready, bvalid, bready;

    logic [15:0] lfsr;
    logic [31:0] shadow [logic [29:0]];
    logic [31:0] inst_q [$];
    logic data_wr_q [$];
    logic [31:0] data_val_q [$];
    logic [3:0] ar_log [$];
    string cur_test;
    int errors, test_start_err, tests_run, tests_failed;
    int aw_cnt, w_cnt, b_cnt;
    logic first_edge_done;
    logic ar_hold, aw_hold, w_hold;
    logic [31:0] ar_addr_p, aw_addr_p, w_data_p;
    logic [3:0] ar_id_p, w_strb_p;
    logic [31:0] rnd, rnd2, rnd3;

    tb_clock_gen u_clk (.clk(clk), .resetn(resetn));

    axi_bridge_top uut (.*);

    tb_axi_slave u_slave (.*);

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // expected word from the shadow copy or the fill rule of the memory
    function automatic logic [31:0] ref_word(logic [31:0] a);
        if (shadow.exists(a[31:2])) return shadow[a[31:2]];
        return a ^ {a[15:0], a[31:16]} ^ 32'h5A3C_96E1;
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] nw,
                                                logic [3:0] st);
        logic [31:0] m;
        m = old;
        for (int b = 0; b < 4; b++) begin
            if (st[b]) m[8*b +: 8] = nw[8*b +: 8];
        end
        return m;
    endfunction

    task automatic check_value(input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL %s: expected %h, actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("error in %s: %s", cur_test, msg);
        errors++;
    endtask

    task automatic issue_inst(input logic [31:0] addr);
        inst_req = 1'b1;
        inst_addr = addr;
        do @(posedge clk); while (!inst_addr_ok);
        inst_q.push_back(ref_word(addr));
        #1 inst_req = 1'b0;
    endtask

    task automatic issue_read(input logic [31:0] addr);
        data_req = 1'b1;
        data_wr = 1'b0;
        data_addr = addr;
        do @(posedge clk); while (!data_addr_ok);
        data_wr_q.push_back(1'b0);
        data_val_q.push_back(ref_word(addr));
        #1 data_req = 1'b0;
    endtask

    task automatic issue_write(input logic [31:0] addr, input logic [31:0] wd,
                               input logic [3:0] st);
        data_req = 1'b1;
        data_wr = 1'b1;
        data_addr = addr;
        data_wdata = wd;
        data_wstrb = st;
        do @(posedge clk); while (!data_addr_ok);
        shadow[addr[31:2]] = merge_bytes(ref_word(addr), wd, st);
        data_wr_q.push_back(1'b1);
        data_val_q.push_back('0);
        #1;
        data_req = 1'b0;
        data_wr = 1'b0;
    endtask

    task automatic wait_idle();
        while (inst_q.size() > 0 || data_wr_q.size() > 0) @(posedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_start_err = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != test_start_err) tests_failed++;
        $display("test %s: %0d errors", cur_test, errors - test_start_err);
    endtask

    // compare process for every data_ok
    always @(posedge clk) begin
        if (resetn && inst_data_ok) begin
            assert (inst_q.size() > 0) else report_error("inst_data_ok with no fetch open");
            if (inst_q.size() > 0) check_value(inst_q.pop_front(), inst_rdata);
        end
        if (resetn && data_data_ok) begin
            assert (data_wr_q.size() > 0) else report_error("data_data_ok with nothing open");
            if (data_wr_q.size() > 0) begin
                if (data_wr_q.pop_front()) begin
                    assert (bvalid) else report_error("write answered by a read response");
                    void'(data_val_q.pop_front());
                    b_cnt++;
                end else begin
                    check_value(data_val_q.pop_front(), data_rdata);
                end
            end
        end
    end

    // bus monitor for holds, idle valids and beat counts
    always @(posedge clk) begin
        if (!resetn && first_edge_done) begin
            assert (!arvalid && !awvalid && !wvalid) else
                report_error("a valid was high during reset");
        end
        if (resetn) begin
            if (ar_hold) begin
                assert (arvalid && araddr == ar_addr_p && arid == ar_id_p) else
                    report_error("read address changed while arready was low");
                assert (!(arvalid && !arready) ||
                        !((data_req && !data_wr && data_addr_ok) || (inst_req && inst_addr_ok)))
                    else report_error("read granted while the read address was stalled");
            end
            if (aw_hold) begin
                assert (awvalid && awaddr == aw_addr_p) else
                    report_error("write address changed while awready was low");
            end
            if (w_hold) begin
                assert (wvalid && wdata == w_data_p && wstrb == w_strb_p) else
                    report_error("write data changed while wready was low");
            end
            if ((aw_hold && awvalid && !awready) || (w_hold && wvalid && !wready)) begin
                assert (!(data_req && data_wr && data_addr_ok)) else
                    report_error("write granted while a write beat was stalled");
            end
            // single beat incr bursts of 4 byte words
            if (arvalid) begin
                check_value(8'd0, arlen);
                check_value(2'b01, arburst);
                check_value(3'd2, arsize);
            end
            if (awvalid) begin
                check_value(4'd1, awid);
                check_value(8'd0, awlen);
                check_value(2'b01, awburst);
                check_value(3'd2, awsize);
            end
            if (wvalid) check_value(1'b1, wlast);
            check_value(1'b1, rready);
            check_value(1'b1, bready);
            if (arvalid && arready) ar_log.push_back(arid);
            if (awvalid && awready) aw_cnt++;
            if (wvalid && wready) w_cnt++;
        end
        first_edge_done = 1'b1;
        ar_hold = resetn && arvalid && !arready;
        aw_hold = resetn && awvalid && !awready;
        w_hold = resetn && wvalid && !wready;
        ar_addr_p = araddr;
        ar_id_p = arid;
        aw_addr_p = awaddr;
        w_data_p = wdata;
        w_strb_p = wstrb;
    end

    initial begin
        #((n_req * 40 + 8) * 4);
        $display("watchdog expired before all requests were answered");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        inst_req = 1'b0;
        inst_size = 2'd2;
        inst_addr = '0;
        data_req = 1'b0;
        data_wr = 1'b0;
        data_size = 2'd2;
        data_wstrb = '0;
        data_addr = '0;
        data_wdata = '0;
        lfsr = 16'd47;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        first_edge_done = 1'b0;

        start_test("reset_idle");
        @(posedge resetn);
        repeat (4) begin
            @(posedge clk);
            assert (!arvalid && !awvalid && !wvalid) else
                report_error("a valid was high with no request after reset");
        end
        #1;
        finish_test();

        start_test("inst_fetch");
        repeat (16) begin
            rnd = take_bits(14);
            issue_inst({16'h1000, rnd[13:0], 2'b00});
        end
        wait_idle();
        finish_test();

        start_test("write_read");
        for (int i = 0; i < 10; i++) begin
            rnd = take_bits(32);
            rnd2 = take_bits(4);
            issue_write(32'h2000_0000 + i * 4, rnd, rnd2[3:0]);
        end
        wait_idle();
        for (int i = 0; i < 10; i++) issue_read(32'h2000_0000 + i * 4);
        wait_idle();
        finish_test();

        start_test("read_priority");
        repeat (4) begin
            rnd = take_bits(14);
            rnd2 = take_bits(14);
            ar_log.delete();
            fork
                issue_inst({16'h1000, rnd[13:0], 2'b00});
                issue_read({16'h1001, rnd2[13:0], 2'b00});
            join
            wait_idle();
            check_value(2, ar_log.size());
            if (ar_log.size() == 2) begin
                check_value(4'd1, ar_log[0]);
                check_value(4'd0, ar_log[1]);
            end
        end
        finish_test();

        start_test("write_split");
        aw_cnt = 0;
        w_cnt = 0;
        b_cnt = 0;
        for (int i = 0; i < 12; i++) begin
            rnd = take_bits(32);
            rnd2 = take_bits(4);
            issue_write(32'h2000_1000 + i * 4, rnd, rnd2[3:0]);
        end
        wait_idle();
        check_value(12, aw_cnt);
        check_value(12, w_cnt);
        check_value(12, b_cnt);
        finish_test();

        // reads and writes in flight together with random readies
        start_test("hold_stable");
        repeat (6) begin
            rnd = take_bits(14);
            rnd2 = take_bits(32);
            rnd3 = take_bits(10);
            fork
                issue_inst({16'h1000, rnd[13:0], 2'b00});
                issue_write({22'h080008, rnd3[9:0]} << 2, rnd2, 4'hF);
            join
        end
        wait_idle();
        finish_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* src.f */
bridge_pkg.sv
bridge_req_if.sv
sram_port_adapter.sv
ar_channel.sv
aw_w_channel.sv
axi_bridge_top.sv
tb_clock_gen.sv
tb_axi_slave.sv
tb_axi_bridge.sv

/* Bender.yml */
package:
  name: axi_bridge

sources:
  - files:
      - bridge_pkg.sv
      - bridge_req_if.sv
      - sram_port_adapter.sv
      - ar_channel.sv
      - aw_w_channel.sv
      - axi_bridge_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_axi_slave.sv
      - tb_axi_bridge.sv
